// ==== Makefile ====
# Verilator simulation of the Gauss-Jordan elimination core

VERILATOR ?= verilator
TOP ?= gauss_jordan_tb
SEED ?= 1
LOG ?= sim.log
BUILD_DIR ?= obj_dir
ERROR_LIMIT ?= 100

FILE_LIST := project.f
SOURCES := $(shell cat $(FILE_LIST))
SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run $(TOP), check $(LOG)"
	@echo "make clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "make help   show this list"
	@echo "Overrides: VERILATOR TOP SEED LOG BUILD_DIR ERROR_LIMIT"

$(SIM): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) --binary --assert --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILE_LIST)

test: $(SIM)
	-$(SIM) +verilator+seed+$(SEED) +verilator+error+limit+$(ERROR_LIMIT) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then echo "FAIL: see $(LOG)"; exit 1; fi
	@if ! grep -q "SIMULATION PASSED" $(LOG); then echo "FAIL: run ended early, see $(LOG)"; exit 1; fi
	@echo "PASS"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== common/inv_pkg.sv ====
`default_nettype none

package inv_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Sizes

	localparam int dim = 5;
	localparam int elem_width = 8;

	// Left half is the matrix, right half the identity it is applied to
	localparam int aug_cols = 2 * dim;

	// Both phases clear dim*(dim-1)/2 elements
	localparam int step_count = dim * (dim - 1) / 2;

	////////////////////////////////////////////////////////////////////////////
	// Types

	// All arithmetic wraps modulo 256
	typedef logic [elem_width-1:0] elem_t;

	typedef elem_t [dim-1:0] row_t;
	typedef row_t [dim-1:0] matrix_t;

	typedef struct packed {
		row_t left;
		row_t right;
	} aug_row_t;

	typedef logic [$clog2(dim)-1:0] idx_t;

	typedef enum logic {
		forward,
		backward
	} phase_t;

	typedef struct packed {
		row_t diagonal;
		matrix_t transform;
	} result_t;

endpackage

`default_nettype wire

// ==== elim/aug_matrix_regs.sv ====
`timescale 1ns/1ns
`default_nettype none

module aug_matrix_regs
(
	input wire logic clk,
	input wire logic load,
	input wire inv_pkg::matrix_t in_matrix,
	input wire logic step_en,
	input wire inv_pkg::idx_t pivot_idx,
	input wire inv_pkg::idx_t row_idx,
	input wire inv_pkg::aug_row_t new_row,
	output inv_pkg::aug_row_t pivot_row,
	output inv_pkg::aug_row_t target_row,
	output inv_pkg::result_t result
);

	inv_pkg::aug_row_t rows [inv_pkg::dim];

	////////////////////////////////////////////////////////////////////////////
	// Storage

	always_ff @(posedge clk)
	begin
		if (load)
		begin
			for (int r = 0; r < inv_pkg::dim; r++)
			begin
				rows[r].left <= in_matrix[r];
				for (int c = 0; c < inv_pkg::dim; c++)
					rows[r].right[c] <= (r == c) ? inv_pkg::elem_t'(1) : '0;
			end
		end
		else if (step_en)
			rows[row_idx] <= new_row;
	end

	////////////////////////////////////////////////////////////////////////////
	// Read side

	assign pivot_row = rows[pivot_idx];
	assign target_row = rows[row_idx];

	// Diagonal from the left half, transform is the whole right half
	always_comb
	begin
		for (int r = 0; r < inv_pkg::dim; r++)
		begin
			result.diagonal[r] = rows[r].left[r];
			result.transform[r] = rows[r].right;
		end
	end

endmodule

`default_nettype wire

// ==== elim/row_update.sv ====
`timescale 1ns/1ns
`default_nettype none

module row_update
(
	input wire inv_pkg::aug_row_t pivot_row,
	input wire inv_pkg::aug_row_t target_row,
	input wire inv_pkg::idx_t pivot_idx,
	output inv_pkg::aug_row_t new_row
);

	// Same bits as an augmented row, seen as ten flat elements
	inv_pkg::elem_t [inv_pkg::aug_cols-1:0] pivot_elems;
	inv_pkg::elem_t [inv_pkg::aug_cols-1:0] target_elems;
	inv_pkg::elem_t [inv_pkg::aug_cols-1:0] new_elems;

	inv_pkg::elem_t pivot_val;
	inv_pkg::elem_t factor;

	assign pivot_elems = pivot_row;
	assign target_elems = target_row;

	assign pivot_val = pivot_row.left[pivot_idx];
	assign factor = target_row.left[pivot_idx];

	// Cross multiply, products truncated to 8 bits
	always_comb
	begin
		for (int i = 0; i < inv_pkg::aug_cols; i++)
			new_elems[i] = target_elems[i] * pivot_val - pivot_elems[i] * factor;
	end

	assign new_row = new_elems;

endmodule

`default_nettype wire

// ==== project.f ====
common/inv_pkg.sv
rtl/elim_fsm.sv
rtl/step_counter.sv
elim/aug_matrix_regs.sv
elim/row_update.sv
rtl/gauss_jordan_top.sv
tb/tb_clock.sv
tb/result_checker.sv
tb/gauss_jordan_properties.sv
tb/gauss_jordan_tb.sv

// ==== rtl/elim_fsm.sv ====
`timescale 1ns/1ns
`default_nettype none

module elim_fsm
(
	input wire logic clk,
	input wire logic reset,
	input wire logic in_valid,
	output logic in_ready,
	input wire logic out_ready,
	output logic out_valid,
	input wire logic phase_last,
	output logic load,
	output logic step_en,
	output inv_pkg::phase_t phase
);

	typedef enum logic [1:0] {
		idle,
		forward,
		backward,
		done
	} state_t;

	state_t state;
	state_t next_state;

	////////////////////////////////////////////////////////////////////////////
	// State register

	always_ff @(posedge clk)
	begin
		if (reset)
			state <= idle;
		else
			state <= next_state;
	end

	always_comb
	begin
		next_state = state;
		case (state)
			idle:
				if (load)
					next_state = forward;
			forward:
				if (phase_last)
					next_state = backward;
			backward:
				if (phase_last)
					next_state = done;
			done:
				if (out_ready)
					next_state = idle;
			default:
				next_state = idle;
		endcase
	end

	////////////////////////////////////////////////////////////////////////////
	// Outputs

	// Only one matrix in flight, so input is open in idle alone
	assign in_ready = (state == idle);
	assign out_valid = (state == done);

	assign load = in_valid && in_ready;

	// One elimination step per cycle through both phases
	assign step_en = (state == forward) || (state == backward);

	assign phase = (state == backward) ? inv_pkg::backward : inv_pkg::forward;

endmodule

`default_nettype wire

// ==== rtl/gauss_jordan_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module gauss_jordan_top
(
	input wire logic clk,
	input wire logic reset,

	input wire logic in_valid,
	output logic in_ready,
	input wire inv_pkg::matrix_t in_matrix,

	output logic out_valid,
	input wire logic out_ready,
	output inv_pkg::result_t result
);

	////////////////////////////////////////////////////////////////////////////
	// Control

	logic load;
	logic step_en;
	inv_pkg::phase_t phase;

	inv_pkg::idx_t pivot_idx;
	inv_pkg::idx_t row_idx;
	logic phase_last;

	elim_fsm u_elim_fsm
	(
		.clk(clk),
		.reset(reset),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.out_ready(out_ready),
		.out_valid(out_valid),
		.phase_last(phase_last),
		.load(load),
		.step_en(step_en),
		.phase(phase)
	);

	step_counter u_step_counter
	(
		.clk(clk),
		.reset(reset),
		.load(load),
		.step_en(step_en),
		.phase(phase),
		.pivot_idx(pivot_idx),
		.row_idx(row_idx),
		.phase_last(phase_last)
	);

	////////////////////////////////////////////////////////////////////////////
	// Elimination datapath

	inv_pkg::aug_row_t pivot_row;
	inv_pkg::aug_row_t target_row;
	inv_pkg::aug_row_t new_row;

	aug_matrix_regs u_aug_matrix_regs
	(
		.clk(clk),
		.load(load),
		.in_matrix(in_matrix),
		.step_en(step_en),
		.pivot_idx(pivot_idx),
		.row_idx(row_idx),
		.new_row(new_row),
		.pivot_row(pivot_row),
		.target_row(target_row),
		.result(result)
	);

	// Row written back on the same edge it is computed
	row_update u_row_update
	(
		.pivot_row(pivot_row),
		.target_row(target_row),
		.pivot_idx(pivot_idx),
		.new_row(new_row)
	);

endmodule

`default_nettype wire

// ==== rtl/step_counter.sv ====
`timescale 1ns/1ns
`default_nettype none

module step_counter
(
	input wire logic clk,
	input wire logic reset,
	input wire logic load,
	input wire logic step_en,
	input wire inv_pkg::phase_t phase,
	output inv_pkg::idx_t pivot_idx,
	output inv_pkg::idx_t row_idx,
	output logic phase_last
);

	localparam int step_width = $clog2(inv_pkg::step_count);

	// Position of the current pair within its phase
	logic [step_width-1:0] step_num;

	always_ff @(posedge clk)
	begin
		if (reset || load)
		begin
			// First forward pair, pivot 0 against row 1
			pivot_idx <= '0;
			row_idx <= inv_pkg::idx_t'(1);
			step_num <= '0;
		end
		else if (step_en)
		begin
			if (phase_last)
			begin
				// End of either phase parks on the first backward pair
				pivot_idx <= inv_pkg::idx_t'(inv_pkg::dim - 1);
				row_idx <= '0;
				step_num <= '0;
			end
			else
			begin
				step_num <= step_num + 1'b1;
				if (phase == inv_pkg::forward)
				begin
					// Rows below the pivot
					if (row_idx == inv_pkg::idx_t'(inv_pkg::dim - 1))
					begin
						pivot_idx <= pivot_idx + inv_pkg::idx_t'(1);
						row_idx <= pivot_idx + inv_pkg::idx_t'(2);
					end
					else
						row_idx <= row_idx + inv_pkg::idx_t'(1);
				end
				else
				begin
					// Rows above the pivot, top down
					if (row_idx == pivot_idx - inv_pkg::idx_t'(1))
					begin
						pivot_idx <= pivot_idx - inv_pkg::idx_t'(1);
						row_idx <= '0;
					end
					else
						row_idx <= row_idx + inv_pkg::idx_t'(1);
				end
			end
		end
	end

	assign phase_last = (step_num == step_width'(inv_pkg::step_count - 1));

endmodule

`default_nettype wire

// ==== tb/gauss_jordan_properties.sv ====
`timescale 1ns/1ns
`default_nettype none

module gauss_jordan_properties
(
	input wire logic clk,
	input wire logic reset,
	input wire logic in_valid,
	input wire logic in_ready,
	input wire logic out_valid,
	input wire logic out_ready,
	input wire inv_pkg::result_t result
);

	// Counts edges since the accepting edge and stops at 21
	logic [4:0] since_accept;

	// Failed assertions so far
	int failures = 0;

	always_ff @(posedge clk)
	begin
		if (reset)
			since_accept <= '0;
		else if (in_valid && in_ready)
			since_accept <= 5'd1;
		else if (since_accept != 5'd0 && since_accept != 5'd21)
			since_accept <= since_accept + 5'd1;
	end

	stall_hold: assert property (@(posedge clk) disable iff (reset)
		out_valid && !out_ready |=> out_valid && $stable(result))
		else
		begin
			failures++;
			$error("result or out_valid changed under back-pressure");
		end

	one_side_open: assert property (@(posedge clk) disable iff (reset)
		!(in_ready && out_valid))
		else
		begin
			failures++;
			$error("in_ready and out_valid high together");
		end

	result_on_time: assert property (@(posedge clk) disable iff (reset)
		since_accept == 5'd20 |=> out_valid)
		else
		begin
			failures++;
			$error("out_valid missing 21 edges after accept");
		end

	no_early_result: assert property (@(posedge clk) disable iff (reset)
		out_valid |-> since_accept == 5'd21)
		else
		begin
			failures++;
			$error("out_valid raised before 21 edges after accept");
		end

endmodule

bind gauss_jordan_top gauss_jordan_properties u_gauss_jordan_properties
(
	.clk(clk),
	.reset(reset),
	.in_valid(in_valid),
	.in_ready(in_ready),
	.out_valid(out_valid),
	.out_ready(out_ready),
	.result(result)
);

`default_nettype wire

// ==== tb/gauss_jordan_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module gauss_jordan_tb;

	// Identity first, then forty random matrices
	localparam int matrix_total = 41;
	localparam int wait_limit = 100;

	logic clk;
	logic reset;
	logic in_valid;
	logic in_ready;
	inv_pkg::matrix_t in_matrix;
	logic out_valid;
	logic out_ready;
	inv_pkg::result_t result;
	int checked_count;
	int checker_errors;

	integer seed = 32'h666ac47a;
	inv_pkg::matrix_t stimulus [matrix_total];
	int gap [matrix_total];
	int stall [matrix_total];
	int tb_errors = 0;
	int timeouts = 0;
	int assert_failures = 0;

	tb_clock u_tb_clock (.clk(clk));

	gauss_jordan_top u_gauss_jordan_top (.*);

	result_checker u_result_checker (.*, .error_count(checker_errors));

	task automatic make_stimulus();
		for (int k = 0; k < matrix_total; k++)
		begin
			for (int r = 0; r < inv_pkg::dim; r++)
				for (int c = 0; c < inv_pkg::dim; c++)
					if (k == 0)
						stimulus[k][r][c] = (r == c) ? 8'd1 : 8'd0;
					else
						stimulus[k][r][c] = inv_pkg::elem_t'($random(seed));
			gap[k] = $random(seed) & 3;
			// First results leave without back-pressure
			stall[k] = (k < 3) ? 0 : $random(seed) & 15;
		end
	endtask

	// Offer each matrix after its gap and hold it until in_ready
	task automatic send_all();
		int waited;
		for (int k = 0; k < matrix_total && timeouts == 0; k++)
		begin
			repeat (gap[k]) @(negedge clk);
			in_matrix = stimulus[k];
			in_valid = 1'b1;
			waited = 0;
			while (!in_ready && waited < wait_limit)
			begin
				@(negedge clk);
				waited++;
			end
			if (in_ready)
				@(negedge clk);
			else
			begin
				timeouts++;
				$display("Timeout: matrix %0d was not accepted within %0d cycles", k, wait_limit);
			end
			in_valid = 1'b0;
		end
	endtask

	// Hold out_ready low for the stall count of each result
	task automatic receive_all();
		int waited;
		int held;
		logic taken;
		for (int k = 0; k < matrix_total && timeouts == 0; k++)
		begin
			waited = 0;
			held = 0;
			taken = 1'b0;
			while (!taken && waited < wait_limit)
			begin
				out_ready = (held >= stall[k]);
				if (out_valid && out_ready)
					taken = 1'b1;
				else
				begin
					if (out_valid)
						held++;
					@(negedge clk);
					waited++;
				end
			end
			if (taken)
				@(negedge clk);
			else
			begin
				timeouts++;
				$display("Timeout: no result for matrix %0d within %0d cycles", k, wait_limit);
			end
		end
	endtask

	initial
	begin
		reset = 1'b1;
		in_valid = 1'b0;
		in_matrix = '0;
		out_ready = 1'b0;
		make_stimulus();
		repeat (10) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		@(negedge clk);
		if (in_ready !== 1'b1)
		begin
			tb_errors++;
			$display("ERR %0t in_ready expected 1 actual %b", $time, in_ready);
		end
		if (out_valid !== 1'b0)
		begin
			tb_errors++;
			$display("ERR %0t out_valid expected 0 actual %b", $time, out_valid);
		end
		fork
			send_all();
			receive_all();
		join
		assert_failures = u_gauss_jordan_top.u_gauss_jordan_properties.failures;
		if (checked_count != matrix_total)
			$display("Only %0d of %0d results were checked", checked_count, matrix_total);
		$display({"Closing: results %0d, checker errors %0d, testbench errors %0d, ",
			"assertion failures %0d, timeouts %0d"},
			checked_count, checker_errors, tb_errors, assert_failures, timeouts);
		if (checker_errors == 0 && tb_errors == 0 && timeouts == 0
			&& assert_failures == 0 && checked_count == matrix_total)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// ==== tb/result_checker.sv ====
`timescale 1ns/1ns
`default_nettype none

module result_checker
(
	input wire logic clk,
	input wire logic reset,
	input wire logic in_valid,
	input wire logic in_ready,
	input wire inv_pkg::matrix_t in_matrix,
	input wire logic out_valid,
	input wire logic out_ready,
	input wire inv_pkg::result_t result,
	output int checked_count,
	output int error_count
);

	inv_pkg::matrix_t accepted [$];
	inv_pkg::result_t expected;
	inv_pkg::result_t held_result;
	logic held = 1'b0;
	logic waiting = 1'b0;
	int edge_num = 0;
	int checked = 0;
	int errors = 0;

	assign checked_count = checked;
	assign error_count = errors;

	// Fraction-free Gauss-Jordan modulo 256 on the identity-augmented matrix
	function automatic inv_pkg::result_t expected_result(input inv_pkg::matrix_t m);
		int a [inv_pkg::dim][inv_pkg::aug_cols];
		int p;
		int pv;
		int f;
		inv_pkg::result_t res;
		for (int r = 0; r < inv_pkg::dim; r++)
			for (int c = 0; c < inv_pkg::dim; c++)
			begin
				a[r][c] = int'(m[r][c]);
				a[r][c + inv_pkg::dim] = (r == c) ? 1 : 0;
			end
		// Pivots 0..3 clear below, then pivots 4..1 clear above, rows top down
		for (int s = 0; s < 2 * inv_pkg::dim - 2; s++)
		begin
			p = (s < inv_pkg::dim - 1) ? s : 2 * inv_pkg::dim - 2 - s;
			for (int r = 0; r < inv_pkg::dim; r++)
			begin
				if ((s < inv_pkg::dim - 1) ? (r > p) : (r < p))
				begin
					pv = a[p][p];
					f = a[r][p];
					for (int c = 0; c < inv_pkg::aug_cols; c++)
						a[r][c] = (a[r][c] * pv - a[p][c] * f) & 255;
				end
			end
		end
		for (int r = 0; r < inv_pkg::dim; r++)
		begin
			res.diagonal[r] = inv_pkg::elem_t'(a[r][r]);
			for (int c = 0; c < inv_pkg::dim; c++)
				res.transform[r][c] = inv_pkg::elem_t'(a[r][c + inv_pkg::dim]);
		end
		return res;
	endfunction

	always @(posedge clk)
	begin
		if (!reset)
		begin
			if (in_ready && out_valid)
			begin
				errors++;
				$display("in_ready and out_valid were both high at %0t", $time);
			end
			if (held && !out_valid)
			begin
				errors++;
				$display("out_valid dropped at %0t before its result was taken", $time);
			end
			if (held && result !== held_result)
			begin
				errors++;
				$display("ERR %0t result expected %h actual %h", $time, held_result, result);
			end
			held = out_valid && !out_ready;
			held_result = result;

			// First out_valid is due 21 edges after the accepting edge
			if (waiting)
			begin
				edge_num++;
				if (out_valid)
				begin
					waiting = 1'b0;
					if (edge_num != 21)
					begin
						errors++;
						$display("ERR %0t out_valid latency expected 21 actual %0d", $time, edge_num);
					end
				end
			end

			if (out_valid && out_ready)
			begin
				if (accepted.size() == 0)
				begin
					errors++;
					$display("Output transfer at %0t with no matrix accepted", $time);
				end
				else
				begin
					expected = expected_result(accepted.pop_front());
					checked++;
					for (int r = 0; r < inv_pkg::dim; r++)
					begin
						if (result.diagonal[r] !== expected.diagonal[r])
						begin
							errors++;
							$display("ERR %0t result.diagonal[%0d] expected %h actual %h",
								$time, r, expected.diagonal[r], result.diagonal[r]);
						end
						if (result.transform[r] !== expected.transform[r])
						begin
							errors++;
							$display("ERR %0t result.transform[%0d] expected %h actual %h",
								$time, r, expected.transform[r], result.transform[r]);
						end
					end
				end
			end

			if (in_valid && in_ready)
			begin
				if (accepted.size() != 0)
				begin
					errors++;
					$display("Matrix accepted at %0t while a result was still pending", $time);
				end
				accepted.push_back(in_matrix);
				waiting = 1'b1;
				edge_num = 0;
			end
		end
	end

endmodule

`default_nettype wire

// ==== tb/tb_clock.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_clock
(
	output logic clk
);

	// 40 ns period
	initial
	begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

endmodule

`default_nettype wire
